// ==== vlog.f ====
+incdir+rtl
rtl/codec_pkg.sv
rtl/apb_regs_pkg.sv
rtl/encoder_8b10b.sv
rtl/decoder_10b8b.sv
rtl/char_fifo.sv
rtl/codec_apb_regs.sv
rtl/link_lane.sv
rtl/line_codec_top.sv
bench/line_codec_sva.sv
bench/tb_line_codec.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the line codec testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_line_codec \
  -f vlog.f -o sim_line_codec
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/sim_line_codec 2>&1)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "Simulation completed successfully"; then
  exit 0
fi
exit 1

// ==== bench/tb_line_codec.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "codec_consts.svh"

module tb_line_codec
  import codec_pkg::*;
  import apb_regs_pkg::*;
;

  localparam int APB_LIMIT   = 16;
  localparam int POLL_LIMIT  = 50;
  localparam int WATCHDOG_NS = 200000;

  localparam status_reg_t ST_TX_FULL  = 5'b00001;
  localparam status_reg_t ST_RX_EMPTY = 5'b00010;
  localparam status_reg_t ST_OVF      = 5'b00100;
  localparam status_reg_t ST_CODE     = 5'b01000;
  localparam status_reg_t ST_ALL      = 5'b11111;
  localparam status_reg_t ST_NONE     = 5'b00000;

  localparam rx_char_t RX_CODE_ERR = 11'h400;
  localparam rx_char_t RX_FLAGS    = 11'h600;
  localparam rx_char_t RX_ALL      = 11'h7FF;
  localparam rx_char_t RX_NONE     = 11'h000;

  localparam logic [`CODEC_APB_AW-1:0] ADDR_UNMAPPED = 4'h2;

  logic                     clk;
  logic                     reset;
  logic                     psel, penable, pwrite;
  logic [`CODEC_APB_AW-1:0] paddr;
  logic [31:0]              pwdata, prdata;
  logic                     pready, pslverr;
  code_sym_t                tx_sym, rx_sym, inject_sym;
  logic                     loop_sel;

  int          errors;
  int          checks;
  logic [31:0] lfsr_state;
  logic        tally_on, tally_known;
  int          tally, sym_ones;

  line_codec_top u_dut (
    .clk_i       (clk),
    .reset_i     (reset),
    .psel_i      (psel),
    .penable_i   (penable),
    .pwrite_i    (pwrite),
    .paddr_i     (paddr),
    .pwdata_i    (pwdata),
    .prdata_o    (prdata),
    .pready_o    (pready),
    .pslverr_o   (pslverr),
    .tx_symbol_o (tx_sym),
    .rx_symbol_i (rx_sym)
  );

  // Loopback or injected symbol into the receiver
  assign rx_sym = loop_sel ? tx_sym : inject_sym;

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired before the tests finished");
    $display("Simulation failed");
    $finish;
  end

  // Running disparity of the transmit stream, RD of -1 or +1
  always @(negedge clk) begin
    if (tally_on) begin
      sym_ones = $countones(tx_sym);
      if (sym_ones < 4 || sym_ones > 6) begin
        errors++;
        $display("Symbol 0x%h on tx_symbol_o has %0d ones", tx_sym, sym_ones);
      end
      if (!tally_known) begin
        if (sym_ones != 5) begin
          tally       = sym_ones - 5;
          tally_known = 1'b1;
        end
      end else begin
        tally = tally + 2 * sym_ones - 10;
        if (tally > 1 || tally < -1) begin
          errors++;
          $display("Running disparity tally reached %0d at symbol 0x%h", tally, tx_sym);
        end
      end
    end
  end

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic code_char_t random_data_char();
    code_char_t c;
    c = '0;
    for (int i = 0; i < 8; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      c.data = {c.data[6:0], lfsr_state[0]};
    end
    return c;
  endfunction

  task automatic check_char(input string name, input code_char_t got, input code_char_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %s: got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_rx(input string name, input rx_char_t got, input rx_char_t exp,
                          input rx_char_t mask);
    checks++;
    if ((got & mask) !== (exp & mask)) begin
      errors++;
      $display("FAIL %s: got 0x%h expected 0x%h", name, got & mask, exp & mask);
    end
  endtask

  task automatic check_status(input string name, input status_reg_t got,
                              input status_reg_t exp, input status_reg_t mask);
    checks++;
    if ((got & mask) !== (exp & mask)) begin
      errors++;
      $display("FAIL %s: got 0x%h expected 0x%h", name, got & mask, exp & mask);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %s: got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  // Setup phase, then access phase until pready
  task automatic apb_access(input logic wr, input logic [`CODEC_APB_AW-1:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic err);
    int waits;
    waits = 0;
    @(negedge clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    @(negedge clk);
    penable = 1'b1;
    #1;
    while (!pready && waits < APB_LIMIT) begin
      @(negedge clk);
      #1;
      waits++;
    end
    if (!pready) begin
      errors++;
      $display("APB access to address 0x%h never completed", addr);
    end
    rdata = prdata;
    err   = pslverr;
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_write(input logic [`CODEC_APB_AW-1:0] addr, input logic [31:0] wdata,
                           output logic err);
    logic [31:0] rdata;
    apb_access(1'b1, addr, wdata, rdata, err);
  endtask

  task automatic apb_read(input logic [`CODEC_APB_AW-1:0] addr, output logic [31:0] rdata,
                          output logic err);
    apb_access(1'b0, addr, 32'd0, rdata, err);
  endtask

  task automatic write_reg(input logic [`CODEC_APB_AW-1:0] addr, input logic [31:0] wdata);
    logic err;
    apb_write(addr, wdata, err);
    check_bit("pslverr_o", err, 1'b0);
  endtask

  task automatic write_char(input code_char_t ch);
    write_reg(`CODEC_REG_TXDATA, {23'd0, ch});
  endtask

  task automatic read_status(output status_reg_t st);
    logic [31:0] rdata;
    logic        err;
    apb_read(`CODEC_REG_STATUS, rdata, err);
    check_bit("pslverr_o", err, 1'b0);
    st = status_reg_t'(rdata[4:0]);
  endtask

  task automatic read_rx(output rx_char_t got);
    logic [31:0] rdata;
    logic        err;
    apb_read(`CODEC_REG_RXDATA, rdata, err);
    check_bit("pslverr_o", err, 1'b0);
    got = rx_char_t'(rdata[10:0]);
  endtask

  task automatic poll_status(input status_reg_t mask, input status_reg_t value,
                             input string what);
    status_reg_t st;
    int          polls;
    polls = 0;
    read_status(st);
    while (((st & mask) !== value) && polls < POLL_LIMIT) begin
      read_status(st);
      polls++;
    end
    if ((st & mask) !== value) begin
      errors++;
      $display("Timed out waiting for %s", what);
    end
  endtask

  task automatic expect_char(input code_char_t exp);
    rx_char_t got;
    poll_status(ST_RX_EMPTY, ST_NONE, "RX data");
    read_rx(got);
    check_char("rx_char.ch", got.ch, exp);
    check_rx("rx_char flags", got, RX_NONE, RX_FLAGS);
  endtask

  task automatic after_reset();
    status_reg_t st;
    rx_char_t    got;
    read_status(st);
    check_status("status", st, ST_RX_EMPTY, ST_ALL);
    read_rx(got);
    check_rx("rxdata", got, RX_NONE, RX_ALL);
  endtask

  task automatic loopback_data();
    code_char_t  sent [8];
    status_reg_t st;
    write_reg(`CODEC_REG_CTRL, 32'd1);
    for (int i = 0; i < 8; i++) begin
      sent[i] = random_data_char();
      write_char(sent[i]);
    end
    for (int i = 0; i < 8; i++) begin
      expect_char(sent[i]);
    end
    // Idle commas must not have reached the RX FIFO
    read_status(st);
    check_status("status", st, ST_RX_EMPTY, ST_ALL);
  endtask

  task automatic loopback_k_chars();
    code_char_t  kc [3];
    status_reg_t st;
    kc[0] = 9'h11C;
    kc[1] = 9'h1FC;
    kc[2] = 9'h1F7;
    for (int i = 0; i < 3; i++) begin
      write_char(kc[i]);
    end
    for (int i = 0; i < 3; i++) begin
      expect_char(kc[i]);
    end
    read_status(st);
    check_status("status", st, ST_RX_EMPTY, ST_ALL);
  endtask

  task automatic disparity_run();
    code_char_t  ch;
    status_reg_t st;
    @(posedge clk);
    tally_known = 1'b0;
    tally       = 0;
    tally_on    = 1'b1;
    for (int i = 0; i < 64; i++) begin
      ch = random_data_char();
      write_char(ch);
      expect_char(ch);
    end
    @(posedge clk);
    tally_on = 1'b0;
    if (!tally_known) begin
      errors++;
      $display("No unbalanced symbol seen during the disparity run");
    end
    read_status(st);
    check_status("status", st, ST_RX_EMPTY, ST_ALL);
  endtask

  task automatic code_error_injection();
    rx_char_t    got;
    status_reg_t st;
    @(negedge clk);
    inject_sym = '0;
    loop_sel   = 1'b0;
    @(negedge clk);
    loop_sel   = 1'b1;
    poll_status(ST_RX_EMPTY, ST_NONE, "injected character");
    read_rx(got);
    check_rx("rx_char.code_err", got, RX_CODE_ERR, RX_CODE_ERR);
    read_status(st);
    check_status("status.rx_code_err", st, ST_CODE, ST_CODE);
    write_reg(`CODEC_REG_STATUS, {27'd0, ST_CODE});
    read_status(st);
    check_status("status.rx_code_err", st, ST_NONE, ST_CODE);
    // The injected symbol may also have upset disparity
    write_reg(`CODEC_REG_STATUS, {27'd0, ST_ALL});
    read_status(st);
    check_status("status", st, ST_RX_EMPTY, ST_ALL);
  endtask

  task automatic back_pressure();
    code_char_t  sent [9];
    status_reg_t st;
    logic [31:0] rdata;
    logic        err;
    write_reg(`CODEC_REG_CTRL, 32'd0);
    for (int i = 0; i < 8; i++) begin
      sent[i] = random_data_char();
      write_char(sent[i]);
    end
    sent[8] = random_data_char();
    apb_write(`CODEC_REG_TXDATA, {23'd0, sent[8]}, err);
    check_bit("pslverr_o on full TXDATA", err, 1'b1);
    read_status(st);
    check_status("status.tx_full", st, ST_TX_FULL, ST_TX_FULL);
    apb_write(ADDR_UNMAPPED, 32'd1, err);
    check_bit("pslverr_o on unmapped write", err, 1'b1);
    apb_read(ADDR_UNMAPPED, rdata, err);
    check_bit("pslverr_o on unmapped read", err, 1'b1);
    // Eight fill the RX FIFO and one more overflows it
    write_reg(`CODEC_REG_CTRL, 32'd1);
    write_char(sent[8]);
    poll_status(ST_OVF, ST_OVF, "RX overflow");
    for (int i = 0; i < 8; i++) begin
      expect_char(sent[i]);
    end
    read_status(st);
    check_status("status", st, ST_RX_EMPTY | ST_OVF, ST_ALL);
    write_reg(`CODEC_REG_STATUS, {27'd0, ST_OVF});
    read_status(st);
    check_status("status", st, ST_RX_EMPTY, ST_ALL);
  endtask

  initial begin
    errors      = 0;
    checks      = 0;
    lfsr_state  = 32'h31da;
    tally_on    = 1'b0;
    tally_known = 1'b0;
    tally       = 0;
    sym_ones    = 0;
    reset       = 1'b1;
    psel        = 1'b0;
    penable     = 1'b0;
    pwrite      = 1'b0;
    paddr       = '0;
    pwdata      = '0;
    inject_sym  = '0;
    loop_sel    = 1'b1;
    repeat (3) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    after_reset();
    loopback_data();
    loopback_k_chars();
    disparity_run();
    code_error_injection();
    back_pressure();

    repeat (4) @(negedge clk);
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== bench/line_codec_sva.sv ====
`timescale 1ns/10ps
`default_nettype none

module line_codec_sva import codec_pkg::*; (
  input logic      clk_i,
  input logic      reset_i,
  input logic      pready_i,
  input logic      tx_pop_i,
  input logic      tx_full_i,
  input logic      rx_pop_i,
  input logic      rx_full_i,
  input code_sym_t tx_symbol_i
);

  pready_high: assert property (@(posedge clk_i) disable iff (reset_i) pready_i)
    else $error("pready_o went low");

  // A full FIFO keeps its occupancy until it is popped
  tx_push_not_full: assert property (@(posedge clk_i) disable iff (reset_i)
    (tx_full_i && !tx_pop_i) |=> tx_full_i)
    else $error("TX FIFO took a push while full");

  rx_push_not_full: assert property (@(posedge clk_i) disable iff (reset_i)
    (rx_full_i && !rx_pop_i) |=> rx_full_i)
    else $error("RX FIFO took a push while full");

  // Valid 8b/10b symbols carry four to six ones
  symbol_weight: assert property (@(posedge clk_i) disable iff (reset_i)
    ($countones(tx_symbol_i) >= 4) && ($countones(tx_symbol_i) <= 6))
    else $error("tx_symbol_o has a bad number of ones");

endmodule

bind line_codec_top line_codec_sva u_sva (
  .clk_i       (clk_i),
  .reset_i     (reset_i),
  .pready_i    (pready_o),
  .tx_pop_i    (tx_pop),
  .tx_full_i   (tx_full),
  .rx_pop_i    (rx_pop),
  .rx_full_i   (rx_full),
  .tx_symbol_i (tx_symbol_o)
);

`default_nettype wire

// ==== rtl/line_codec_top.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "codec_consts.svh"

module line_codec_top import codec_pkg::*; (
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  logic                     psel_i,
  input  logic                     penable_i,
  input  logic                     pwrite_i,
  input  logic [`CODEC_APB_AW-1:0] paddr_i,
  input  logic [31:0]              pwdata_i,
  output logic [31:0]              prdata_o,
  output logic                     pready_o,
  output logic                     pslverr_o,
  output code_sym_t                tx_symbol_o,
  input  code_sym_t                rx_symbol_i
);

  logic       tx_push, tx_full, tx_pop, tx_empty, tx_enable;
  code_char_t tx_wr_char, tx_head;
  logic       rx_push, rx_full, rx_pop, rx_empty, rx_overflow;
  rx_char_t   rx_wr_char, rx_head;

  codec_apb_regs u_regs (
    .*,
    .tx_push_o     (tx_push),
    .tx_char_o     (tx_wr_char),
    .tx_full_i     (tx_full),
    .rx_pop_o      (rx_pop),
    .rx_char_i     (rx_head),
    .rx_empty_i    (rx_empty),
    .rx_overflow_i (rx_overflow),
    .tx_enable_o   (tx_enable)
  );

  char_fifo #(.payload_t(code_char_t), .DEPTH(`CODEC_FIFO_DEPTH)) u_tx_fifo (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .push_i  (tx_push),
    .data_i  (tx_wr_char),
    .full_o  (tx_full),
    .pop_i   (tx_pop),
    .data_o  (tx_head),
    .empty_o (tx_empty)
  );

  char_fifo #(.payload_t(rx_char_t), .DEPTH(`CODEC_FIFO_DEPTH)) u_rx_fifo (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .push_i  (rx_push),
    .data_i  (rx_wr_char),
    .full_o  (rx_full),
    .pop_i   (rx_pop),
    .data_o  (rx_head),
    .empty_o (rx_empty)
  );

  link_lane u_lane (
    .*,
    .tx_enable_i   (tx_enable),
    .tx_char_i     (tx_head),
    .tx_empty_i    (tx_empty),
    .tx_pop_o      (tx_pop),
    .rx_push_o     (rx_push),
    .rx_char_o     (rx_wr_char),
    .rx_full_i     (rx_full),
    .rx_overflow_o (rx_overflow)
  );

endmodule

`default_nettype wire

// ==== rtl/link_lane.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "codec_consts.svh"

module link_lane import codec_pkg::*; (
  input  logic       clk_i,
  input  logic       reset_i,
  input  logic       tx_enable_i,
  input  code_char_t tx_char_i,
  input  logic       tx_empty_i,
  output logic       tx_pop_o,
  output code_sym_t  tx_symbol_o,
  input  code_sym_t  rx_symbol_i,
  output logic       rx_push_o,
  output rx_char_t   rx_char_o,
  input  logic       rx_full_i,
  output logic       rx_overflow_o
);

  // K28.5 at negative disparity, 001111 1010 in line order
  localparam code_sym_t COMMA_NEG = 10'b0101_111100;

  code_char_t tx_char;
  code_sym_t  tx_sym;
  logic       tx_disp_q, tx_disp_next;
  logic       rx_disp_q, rx_disp_next;
  logic       rx_comma;

  // Idle comma whenever there is nothing to send
  assign tx_pop_o = tx_enable_i & ~tx_empty_i;
  assign tx_char  = tx_pop_o ? tx_char_i : code_char_t'(`CODEC_K28_5);

  encoder_8b10b u_encoder (
    .in_char_i (tx_char),
    .disp_i    (tx_disp_q),
    .symbol_o  (tx_sym),
    .disp_o    (tx_disp_next)
  );

  decoder_10b8b u_decoder (
    .symbol_i  (rx_symbol_i),
    .disp_i    (rx_disp_q),
    .rx_char_o (rx_char_o),
    .disp_o    (rx_disp_next)
  );

  // Commas are dropped even when they carry a disparity error
  assign rx_comma      = ~rx_char_o.code_err & (rx_char_o.ch == code_char_t'(`CODEC_K28_5));
  assign rx_push_o     = ~rx_comma & ~rx_full_i;
  assign rx_overflow_o = ~rx_comma & rx_full_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      tx_symbol_o <= COMMA_NEG;
      tx_disp_q   <= 1'b0;
      rx_disp_q   <= 1'b0;
    end else begin
      tx_symbol_o <= tx_sym;
      tx_disp_q   <= tx_disp_next;
      rx_disp_q   <= rx_disp_next;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/codec_apb_regs.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "codec_consts.svh"

module codec_apb_regs
  import codec_pkg::*;
  import apb_regs_pkg::*;
(
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  logic                     psel_i,
  input  logic                     penable_i,
  input  logic                     pwrite_i,
  input  logic [`CODEC_APB_AW-1:0] paddr_i,
  input  logic [31:0]              pwdata_i,
  output logic [31:0]              prdata_o,
  output logic                     pready_o,
  output logic                     pslverr_o,
  output logic                     tx_push_o,
  output code_char_t               tx_char_o,
  input  logic                     tx_full_i,
  output logic                     rx_pop_o,
  input  rx_char_t                 rx_char_i,
  input  logic                     rx_empty_i,
  input  logic                     rx_overflow_i,
  output logic                     tx_enable_o
);

  logic        access, wr, rd, clr_status;
  logic        sel_ctrl, sel_status, sel_tx, sel_rx, mapped;
  ctrl_reg_t   ctrl_q;
  status_reg_t status, status_wr;
  logic        ovf_q, code_err_q, disp_err_q;

  // Zero wait states so every access ends in its access phase
  assign access = psel_i & penable_i;
  assign wr     = access & pwrite_i;
  assign rd     = access & ~pwrite_i;

  assign sel_ctrl   = (paddr_i == `CODEC_REG_CTRL);
  assign sel_status = (paddr_i == `CODEC_REG_STATUS);
  assign sel_tx     = (paddr_i == `CODEC_REG_TXDATA);
  assign sel_rx     = (paddr_i == `CODEC_REG_RXDATA);
  assign mapped     = sel_ctrl | sel_status | sel_tx | sel_rx;

  assign pready_o  = 1'b1;
  assign pslverr_o = access & (~mapped | (pwrite_i & sel_tx & tx_full_i));

  assign tx_push_o   = wr & sel_tx & ~tx_full_i;
  assign tx_char_o   = code_char_t'(pwdata_i[8:0]);
  assign rx_pop_o    = rd & sel_rx & ~rx_empty_i;
  assign tx_enable_o = ctrl_q.tx_enable;

  assign status.tx_full     = tx_full_i;
  assign status.rx_empty    = rx_empty_i;
  assign status.rx_overflow = ovf_q;
  assign status.rx_code_err = code_err_q;
  assign status.rx_disp_err = disp_err_q;

  assign status_wr  = status_reg_t'(pwdata_i[4:0]);
  assign clr_status = wr & sel_status;

  always_comb begin
    case (paddr_i)
      `CODEC_REG_CTRL:   prdata_o = {31'd0, ctrl_q};
      `CODEC_REG_STATUS: prdata_o = {27'd0, status};
      `CODEC_REG_RXDATA: prdata_o = rx_empty_i ? 32'd0 : {21'd0, rx_char_i};
      default:           prdata_o = 32'd0;
    endcase
  end

  // Sticky bits set on the popped character and a new event wins over a clear
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ctrl_q     <= '0;
      ovf_q      <= 1'b0;
      code_err_q <= 1'b0;
      disp_err_q <= 1'b0;
    end else begin
      if (wr && sel_ctrl) begin
        ctrl_q <= ctrl_reg_t'(pwdata_i[0]);
      end
      ovf_q      <= rx_overflow_i | (ovf_q & ~(clr_status & status_wr.rx_overflow));
      code_err_q <= (rx_pop_o & rx_char_i.code_err) |
                    (code_err_q & ~(clr_status & status_wr.rx_code_err));
      disp_err_q <= (rx_pop_o & rx_char_i.disp_err) |
                    (disp_err_q & ~(clr_status & status_wr.rx_disp_err));
    end
  end

endmodule

`default_nettype wire

// ==== rtl/char_fifo.sv ====
`timescale 1ns/10ps
`default_nettype none

module char_fifo #(
  parameter type payload_t = logic [7:0],
  parameter int  DEPTH     = 8
) (
  input  logic     clk_i,
  input  logic     reset_i,
  input  logic     push_i,
  input  payload_t data_i,
  output logic     full_o,
  input  logic     pop_i,
  output payload_t data_o,
  output logic     empty_o
);

  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW = $clog2(DEPTH + 1);

  payload_t      mem [DEPTH];
  logic [AW-1:0] wr_ptr, rd_ptr;
  logic [CW-1:0] count;
  logic          do_push, do_pop;

  assign full_o  = (count == CW'(DEPTH));
  assign empty_o = (count == '0);
  assign do_push = push_i & ~full_o;
  assign do_pop  = pop_i & ~empty_o;
  assign data_o  = mem[rd_ptr];

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem[wr_ptr] <= data_i;
    end
  end

  // Pointers wrap at DEPTH so any depth works
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count <= count + CW'(do_push) - CW'(do_pop);
    end
  end

endmodule

`default_nettype wire

// ==== rtl/decoder_10b8b.sv ====
`timescale 1ns/10ps
`default_nettype none

module decoder_10b8b import codec_pkg::*; (
  input  code_sym_t symbol_i,
  input  logic      disp_i,
  output rx_char_t  rx_char_o,
  output logic      disp_o
);

  logic [5:0] s6;
  logic [3:0] s4, s4_lut;
  logic [4:0] d5;
  logic [2:0] d3;
  logic [2:0] ones6, ones4;
  logic       ok6, ok4, k28, alt7, rd6, err6, err4;

  // Subblocks in line order, a and f leftmost as in the code tables
  assign s6 = {symbol_i[0], symbol_i[1], symbol_i[2], symbol_i[3], symbol_i[4], symbol_i[5]};
  assign s4 = {symbol_i[6], symbol_i[7], symbol_i[8], symbol_i[9]};

  always_comb begin
    d5  = 5'd0;
    ok6 = 1'b1;
    case (s6)
      6'b100111, 6'b011000: d5 = 5'd0;
      6'b011101, 6'b100010: d5 = 5'd1;
      6'b101101, 6'b010010: d5 = 5'd2;
      6'b110001:            d5 = 5'd3;
      6'b110101, 6'b001010: d5 = 5'd4;
      6'b101001:            d5 = 5'd5;
      6'b011001:            d5 = 5'd6;
      6'b111000, 6'b000111: d5 = 5'd7;
      6'b111001, 6'b000110: d5 = 5'd8;
      6'b100101:            d5 = 5'd9;
      6'b010101:            d5 = 5'd10;
      6'b110100:            d5 = 5'd11;
      6'b001101:            d5 = 5'd12;
      6'b101100:            d5 = 5'd13;
      6'b011100:            d5 = 5'd14;
      6'b010111, 6'b101000: d5 = 5'd15;
      6'b011011, 6'b100100: d5 = 5'd16;
      6'b100011:            d5 = 5'd17;
      6'b010011:            d5 = 5'd18;
      6'b110010:            d5 = 5'd19;
      6'b001011:            d5 = 5'd20;
      6'b101010:            d5 = 5'd21;
      6'b011010:            d5 = 5'd22;
      6'b111010, 6'b000101: d5 = 5'd23;
      6'b110011, 6'b001100: d5 = 5'd24;
      6'b100110:            d5 = 5'd25;
      6'b010110:            d5 = 5'd26;
      6'b110110, 6'b001001: d5 = 5'd27;
      6'b001110, 6'b001111, 6'b110000: d5 = 5'd28;
      6'b101110, 6'b010001: d5 = 5'd29;
      6'b011110, 6'b100001: d5 = 5'd30;
      6'b101011, 6'b010100: d5 = 5'd31;
      default:              ok6 = 1'b0;
    endcase
  end

  assign k28 = (s6 == 6'b001111) || (s6 == 6'b110000);

  // K28 at positive disparity sends its 4b subblock inverted
  assign s4_lut = (s6 == 6'b110000) ? ~s4 : s4;

  always_comb begin
    d3  = 3'd0;
    ok4 = 1'b1;
    case (s4_lut)
      4'b1011, 4'b0100: d3 = 3'd0;
      4'b1001:          d3 = 3'd1;
      4'b0101:          d3 = 3'd2;
      4'b1100, 4'b0011: d3 = 3'd3;
      4'b1101, 4'b0010: d3 = 3'd4;
      4'b1010:          d3 = 3'd5;
      4'b0110:          d3 = 3'd6;
      4'b1110, 4'b0001, 4'b0111, 4'b1000: d3 = 3'd7;
      default:          ok4 = 1'b0;
    endcase
  end

  assign alt7 = (s4_lut == 4'b0111) || (s4_lut == 4'b1000);

  // Unbalanced subblocks set the disparity and balanced ones keep it
  assign ones6  = 3'($countones(s6));
  assign ones4  = 3'($countones(s4));
  assign rd6    = (ones6 > 3'd3) ? 1'b1 : ((ones6 < 3'd3) ? 1'b0 : disp_i);
  assign disp_o = (ones4 > 3'd2) ? 1'b1 : ((ones4 < 3'd2) ? 1'b0 : rd6);

  assign err6 = ((ones6 > 3'd3) & disp_i) | ((ones6 < 3'd3) & ~disp_i) |
                ((s6 == 6'b111000) & disp_i) | ((s6 == 6'b000111) & ~disp_i);
  assign err4 = ((ones4 > 3'd2) & rd6) | ((ones4 < 3'd2) & ~rd6) |
                ((s4 == 4'b1100) & rd6) | ((s4 == 4'b0011) & ~rd6);

  // Table misses also cover any subblock imbalance above two
  assign rx_char_o.code_err = ~ok6 | ~ok4;
  assign rx_char_o.disp_err = err6 | err4;
  assign rx_char_o.ch.data  = {d3, d5};
  assign rx_char_o.ch.k     = k28 | (alt7 & ((d5 == 5'd23) | (d5 == 5'd27) |
                                             (d5 == 5'd29) | (d5 == 5'd30)));

endmodule

`default_nettype wire

// ==== rtl/encoder_8b10b.sv ====
`timescale 1ns/10ps
`default_nettype none

module encoder_8b10b import codec_pkg::*; (
  input  code_char_t in_char_i,
  input  logic       disp_i,
  output code_sym_t  symbol_o,
  output logic       disp_o
);

  logic a, b, c, d, e, f, g, h, k;
  logic a_eq_b, c_eq_d;
  logic l22, l40, l04, l13, l31;
  logic ed_only, e_unbal;
  logic a6, b6, c6, d6, e6, i6;
  logic f4, g4, h4, j4;
  logic nd1s6, pd1s6, ndos6, pdos6;
  logic nd1s4, pd1s4, ndos4, pdos4;
  logic alt7, compl6, compl4, disp6;

  assign {h, g, f, e, d, c, b, a} = in_char_i.data;
  assign k = in_char_i.k;

  // Classify ABCD by its count of ones
  assign a_eq_b  = ~(a ^ b);
  assign c_eq_d  = ~(c ^ d);
  assign l22     = (a & b & ~c & ~d) | (c & d & ~a & ~b) | (~a_eq_b & ~c_eq_d);
  assign l40     = a & b & c & d;
  assign l04     = ~(a | b | c | d);
  assign l13     = (~a_eq_b & ~c & ~d) | (~c_eq_d & ~a & ~b);
  assign l31     = (~a_eq_b & c & d) | (~c_eq_d & a & b);
  assign ed_only = e & d & ~c & ~b & ~a;
  assign e_unbal = e & ~l22 & ~l13;

  // 5b/6b subblock before complementing
  assign a6 = a;
  assign b6 = (b & ~l40) | l04;
  assign c6 = l04 | c | ed_only;
  assign d6 = d & ~(a & b & c);
  assign e6 = (e | l13) & ~ed_only;
  assign i6 = (l22 & ~e) | (e & ~d & ~c & ~(a & b)) | (e & l40) |
              (k & e & d & c & ~b & ~a) | (e & ~d & c & ~b & ~a);

  assign pd1s6 = ed_only | (~e & ~l22 & ~l31);
  assign nd1s6 = k | e_unbal | (~e & ~d & c & b & a);
  assign ndos6 = pd1s6;
  assign pdos6 = k | e_unbal;

  // Alternate 7 breaks up a run of five equal bits
  assign alt7 = f & g & h & (k | (disp_i ? (~e & d & l31) : (e & ~d & l13)));

  // 3b/4b subblock
  assign f4 = f & ~alt7;
  assign g4 = g | ~(f | g | h);
  assign h4 = h;
  assign j4 = (~h & (f ^ g)) | alt7;

  assign nd1s4 = f & g;
  assign pd1s4 = ~(f | g) | (k & (f ^ g));
  assign ndos4 = ~(f | g);
  assign pdos4 = f & g & h;

  // Each subblock is complemented against the disparity it starts from
  assign compl6 = disp_i ? nd1s6 : pd1s6;
  assign disp6  = disp_i ^ (ndos6 | pdos6);
  assign compl4 = disp6 ? nd1s4 : pd1s4;
  assign disp_o = disp6 ^ (ndos4 | pdos4);

  assign symbol_o = {{j4, h4, g4, f4} ^ {4{compl4}}, {i6, e6, d6, c6, b6, a6} ^ {6{compl6}}};

endmodule

`default_nettype wire

// ==== rtl/apb_regs_pkg.sv ====
`default_nettype none

package apb_regs_pkg;

  typedef struct packed {
    logic tx_enable;
  } ctrl_reg_t;

  // Upper three bits are sticky and cleared by writing one
  typedef struct packed {
    logic rx_disp_err;
    logic rx_code_err;
    logic rx_overflow;
    logic rx_empty;
    logic tx_full;
  } status_reg_t;

endpackage

`default_nettype wire

// ==== rtl/codec_pkg.sv ====
`default_nettype none

package codec_pkg;

  // K flag sits above the data byte
  typedef struct packed {
    logic       k;
    logic [7:0] data;
  } code_char_t;

  // Line symbol {j h g f i e d c b a} with bit a sent first
  typedef logic [9:0] code_sym_t;

  // Received character and its line errors
  typedef struct packed {
    logic       code_err;
    logic       disp_err;
    code_char_t ch;
  } rx_char_t;

endpackage

`default_nettype wire

// ==== rtl/codec_consts.svh ====
`ifndef CODEC_CONSTS_SVH
`define CODEC_CONSTS_SVH

// Entries in each character FIFO
`define CODEC_FIFO_DEPTH 8

// APB address width and register offsets
`define CODEC_APB_AW     4
`define CODEC_REG_CTRL   4'h0
`define CODEC_REG_STATUS 4'h4
`define CODEC_REG_TXDATA 4'h8
`define CODEC_REG_RXDATA 4'hC

// Idle comma K28.5 with the K flag in bit 8
`define CODEC_K28_5      9'h1BC

`endif
